/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu
FILELIST = project.f
LOG      = sim.log
BUILD    = obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* cpu_checker.sv */
`include "cpu_macros.svh"

module cpu_checker #(
    parameter int ROWS = 64
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`XLEN-1:0]            memory_data_out,
    input  logic [1:0]                  memory_data_size,
    input  logic                        memory_operation,
    input  logic                        result_valid,
    input  logic [`XLEN-1:0]            result_value,
    input  logic [`REG_INDEX_WIDTH-1:0] result_destination,
    input  int                          row_op [ROWS],
    input  int                          row_rd [ROWS],
    input  int                          row_rs1 [ROWS],
    input  int                          row_rs2 [ROWS],
    input  int                          row_imm [ROWS],
    input  int                          row_count,
    output int                          error_count,
    output int                          outstanding,
    output logic                        model_ready
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int IMM = 16;
    localparam int RAW = 31;

    logic [31:0] expected [32][$];   // Per destination, in program order
    logic [31:0] regs [32];

    function automatic logic [31:0] model_alu(input int alu, input logic [31:0] a, b);
        case (alu)
            ALU_SUB:  return a - b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLTU: return {31'b0, a < b};
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            default:  return a + b;
        endcase
    endfunction

    task automatic build_model();
        logic [31:0] b;
        logic [31:0] value;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int i = 0; i < row_count; i++) begin
            if (row_op[i] != RAW) begin
                b     = (row_op[i] >= IMM) ? 32'(row_imm[i]) : regs[row_rs2[i]];
                value = model_alu(row_op[i] % IMM, regs[row_rs1[i]], b);
                if (row_rd[i] != 0) regs[row_rd[i]] = value;   // x0 stays zero
                expected[row_rd[i]].push_back(value);
                outstanding++;
            end
        end
        model_ready = 1'b1;
    endtask

    initial begin
        error_count = 0;
        outstanding = 0;
        model_ready = 1'b0;
    end

    always @(posedge clock) begin
        int d;
        d = int'(result_destination);
        if (!reset && !model_ready) begin
            build_model();
        end else if (!reset && result_valid) begin
            if (expected[d].size() > 0) begin
                if (expected[d][0] !== result_value) begin
                    $display("FAIL %0t result_value x%0d: expected %h, got %h",
                             $time, d, expected[d][0], result_value);
                    error_count++;
                end
                expected[d].delete(0);   // Oldest write to this register
                outstanding--;
            end else if (d != 0 || result_value !== '0) begin // Fill NOPs write zero to x0
                $display("Unexpected result for x%0d with nothing outstanding at %0t", d, $time);
                error_count++;
            end
        end
        if (!reset) begin
            if (memory_data_out !== '0) begin
                $display("FAIL %0t memory_data_out: expected %h, got %h",
                         $time, `XLEN'(0), memory_data_out);
                error_count++;
            end
            if (memory_data_size !== 2'd2) begin
                $display("FAIL %0t memory_data_size: expected %0d, got %0d",
                         $time, 2'd2, memory_data_size);
                error_count++;
            end
            if (memory_operation !== 1'b0) begin
                $display("FAIL %0t memory_operation: expected %0d, got %0d",
                         $time, 1'b0, memory_operation);
                error_count++;
            end
        end
    end

endmodule

/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define XLEN 32

// Register file index
`define REG_INDEX_WIDTH 5

// Reservation stations and their index width
`define STATION_COUNT 4
`define TAG_WIDTH 2

// Program counter step
`define INSTR_BYTES 4

`endif

/* cpu_pkg.sv */
package cpu_pkg;

    // Major opcodes handled by decode
    typedef enum logic [6:0] {
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_AND  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_SLT  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0, // Waiting for memory to go idle
        FETCH_WAIT = 2'd1, // Request outstanding
        FETCH_HELD = 2'd2  // Word taken, memory still ready
    } fetch_state_e;

endpackage

/* cpu_properties.sv */
`include "cpu_macros.svh"

module cpu_properties (
    input logic                  clock,
    input logic                  reset,
    input logic                  memory_enable,
    input logic [`XLEN-1:0]      memory_address,
    input logic                  issue_accept,
    input logic [`TAG_WIDTH-1:0] issue_tag,
    input logic                  result_valid,
    input logic [`TAG_WIDTH-1:0] result_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`STATION_COUNT-1:0] issued;   // Stations holding an instruction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issued <= '0;
        end else begin
            if (issue_accept) begin
                issued[issue_tag] <= 1'b1;
            end
            if (result_valid) begin
                issued[result_tag] <= 1'b0;
            end
        end
    end

    enable_low_in_reset: assert property (@(posedge clock) reset |-> !memory_enable)
        else $error("memory_enable high while in reset");

    single_cycle_result: assert property (
        @(posedge clock) disable iff (reset) result_valid |=> !result_valid)
        else $error("result_valid held for two cycles");

    tag_issued: assert property (
        @(posedge clock) disable iff (reset) result_valid |-> issued[result_tag])
        else $error("result_tag names a station with no instruction");

    // Enable falls on the capture edge
    address_step: assert property (@(posedge clock) disable iff (reset)
        $fell(memory_enable) |-> memory_address == $past(memory_address) + `XLEN'(`INSTR_BYTES))
        else $error("memory_address did not advance by one word");

endmodule

bind cpu_top cpu_properties props (
    .clock, .reset, .memory_enable, .memory_address, .issue_accept, .issue_tag,
    .result_valid, .result_tag
);

/* cpu_top.sv */
`include "cpu_macros.svh"

module cpu_top (
    input  logic                        clock,
    input  logic                        reset,
    output logic [`XLEN-1:0]            memory_address,
    input  logic [`XLEN-1:0]            memory_data_in,
    output logic [`XLEN-1:0]            memory_data_out,
    output logic [1:0]                  memory_data_size,
    output logic                        memory_enable,
    output logic                        memory_operation,
    input  logic                        memory_ready,
    output logic                        result_valid,
    output logic [`TAG_WIDTH-1:0]       result_tag,
    output logic [`XLEN-1:0]            result_value,
    output logic [`REG_INDEX_WIDTH-1:0] result_destination
);
    import cpu_pkg::*;

    logic [`XLEN-1:0]            instruction;
    logic                        instruction_valid;
    logic                        issue_accept;
    logic                        fetch_accept;
    logic [`TAG_WIDTH-1:0]       issue_tag;
    alu_op_e                     alu_op;
    logic [`REG_INDEX_WIDTH-1:0] source_1_index;
    logic [`REG_INDEX_WIDTH-1:0] source_2_index;
    logic [`REG_INDEX_WIDTH-1:0] destination_index;
    logic                        use_immediate;
    logic [`XLEN-1:0]            immediate;
    logic                        decode_known;
    logic                        source_1_ready;
    logic                        source_2_ready;
    logic [`XLEN-1:0]            source_1_value;
    logic [`XLEN-1:0]            source_2_value;
    logic [`TAG_WIDTH-1:0]       source_1_tag;
    logic [`TAG_WIDTH-1:0]       source_2_tag;

    assign memory_data_out  = '0;
    assign memory_data_size = 2'd2;  // Word
    assign memory_operation = 1'b0;  // Read only

    // Unknown words leave the slot without taking a station
    assign fetch_accept = issue_accept || (instruction_valid && !decode_known);

    fetch_unit u_fetch (
        .clock, .reset, .memory_data_in, .memory_ready,
        .issue_accept (fetch_accept),
        .memory_address, .memory_enable, .instruction, .instruction_valid
    );

    decode_unit u_decode (
        .instruction, .alu_op, .source_1_index, .source_2_index,
        .destination_index, .use_immediate, .immediate, .decode_known
    );

    register_status u_registers (
        .clock, .reset, .source_1_index, .source_2_index,
        .source_1_ready, .source_1_value, .source_1_tag,
        .source_2_ready, .source_2_value, .source_2_tag,
        .issue_accept, .destination_index, .issue_tag,
        .result_valid, .result_tag, .result_value
    );

    station_pool u_stations (
        .clock, .reset, .instruction_valid, .decode_known, .alu_op,
        .use_immediate, .immediate, .destination_index,
        .source_1_ready, .source_1_value, .source_1_tag,
        .source_2_ready, .source_2_value, .source_2_tag,
        .issue_accept, .issue_tag,
        .result_valid, .result_tag, .result_value, .result_destination
    );

endmodule

/* decode_unit.sv */
`include "cpu_macros.svh"

module decode_unit (
    input  logic [`XLEN-1:0]            instruction,
    output cpu_pkg::alu_op_e            alu_op,
    output logic [`REG_INDEX_WIDTH-1:0] source_1_index,
    output logic [`REG_INDEX_WIDTH-1:0] source_2_index,
    output logic [`REG_INDEX_WIDTH-1:0] destination_index,
    output logic                        use_immediate,
    output logic [`XLEN-1:0]            immediate,
    output logic                        decode_known
);
    import cpu_pkg::*;

    opcode_e          opcode;
    logic [2:0]       function_3;
    logic [6:0]       function_7;
    logic [`XLEN-1:0] immediate_i;
    logic [`XLEN-1:0] shift_amount;
    logic             function_7_zero;
    logic             function_7_alt;

    assign opcode            = opcode_e'(instruction[6:0]);
    assign function_3        = instruction[14:12];
    assign function_7        = instruction[31:25];
    assign source_1_index    = instruction[19:15];
    assign source_2_index    = instruction[24:20];
    assign destination_index = instruction[11:7];

    assign immediate_i  = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
    assign shift_amount = {{(`XLEN-5){1'b0}}, instruction[24:20]}; // Low five bits only

    assign function_7_zero = function_7 == 7'b0000000;
    assign function_7_alt  = function_7 == 7'b0100000; // Bit 30 set, SUB and SRA

    always_comb begin
        alu_op        = ALU_ADD;
        use_immediate = 1'b0;
        immediate     = immediate_i;
        decode_known  = 1'b0;

        case (opcode)
            OPCODE_OP_IMM: begin
                use_immediate = 1'b1;
                decode_known  = 1'b1;
                case (function_3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op       = ALU_SLL;
                        immediate    = shift_amount;
                        decode_known = function_7_zero;
                    end
                    default: begin // 3'b101
                        alu_op       = instruction[30] ? ALU_SRA : ALU_SRL;
                        immediate    = shift_amount;
                        decode_known = function_7_zero || function_7_alt;
                    end
                endcase
            end
            OPCODE_OP: begin
                decode_known = function_7_zero;
                case (function_3)
                    3'b000: begin
                        alu_op       = instruction[30] ? ALU_SUB : ALU_ADD;
                        decode_known = function_7_zero || function_7_alt;
                    end
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: begin // 3'b101
                        alu_op       = instruction[30] ? ALU_SRA : ALU_SRL;
                        decode_known = function_7_zero || function_7_alt;
                    end
                endcase
            end
            default: decode_known = 1'b0;
        endcase
    end

endmodule

/* fetch_unit.sv */
`include "cpu_macros.svh"

module fetch_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic [`XLEN-1:0] memory_data_in,
    input  logic             memory_ready,
    input  logic             issue_accept,
    output logic [`XLEN-1:0] memory_address,
    output logic             memory_enable,
    output logic [`XLEN-1:0] instruction,
    output logic             instruction_valid
);
    import cpu_pkg::*;

    fetch_state_e state;
    logic         capture;

    // Data is only taken when the decode slot is empty
    assign capture = (state == FETCH_WAIT) && memory_ready && !instruction_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state             <= FETCH_IDLE;
            memory_enable     <= 1'b0;
            memory_address    <= '0;
            instruction_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!memory_ready) begin
                        memory_enable <= 1'b1;
                        state         <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (capture) begin
                        memory_enable  <= 1'b0;
                        memory_address <= memory_address + `XLEN'(`INSTR_BYTES); // Next word
                        state          <= FETCH_HELD;
                    end
                end
                FETCH_HELD: begin
                    if (!memory_ready) begin // Memory has seen enable fall
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase

            if (capture) begin
                instruction_valid <= 1'b1;
            end else if (issue_accept) begin
                instruction_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            instruction <= memory_data_in;
        end
    end

endmodule

/* project.f */
+incdir+.
cpu_pkg.sv
fetch_unit.sv
decode_unit.sv
register_status.sv
station_pool.sv
cpu_top.sv
cpu_properties.sv
cpu_checker.sv
tb_cpu.sv

/* register_status.sv */
`include "cpu_macros.svh"

module register_status (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`REG_INDEX_WIDTH-1:0] source_1_index,
    input  logic [`REG_INDEX_WIDTH-1:0] source_2_index,
    output logic                        source_1_ready,
    output logic [`XLEN-1:0]            source_1_value,
    output logic [`TAG_WIDTH-1:0]       source_1_tag,
    output logic                        source_2_ready,
    output logic [`XLEN-1:0]            source_2_value,
    output logic [`TAG_WIDTH-1:0]       source_2_tag,
    input  logic                        issue_accept,
    input  logic [`REG_INDEX_WIDTH-1:0] destination_index,
    input  logic [`TAG_WIDTH-1:0]       issue_tag,
    input  logic                        result_valid,
    input  logic [`TAG_WIDTH-1:0]       result_tag,
    input  logic [`XLEN-1:0]            result_value
);
    // x0 has no storage
    logic [`XLEN-1:0]      values [1:31];
    logic [`TAG_WIDTH-1:0] tags   [1:31];
    logic [31:1]           busy;
    logic [31:1]           retire;

    function automatic void lookup(
        input  logic [`REG_INDEX_WIDTH-1:0] index,
        output logic                        ready,
        output logic [`XLEN-1:0]            value,
        output logic [`TAG_WIDTH-1:0]       tag
    );
        ready = 1'b1;
        value = '0;
        tag   = '0;
        if (index != '0) begin
            tag   = tags[index];
            value = values[index];
            if (busy[index]) begin
                ready = result_valid && (result_tag == tags[index]);
                value = result_value; // Forwarded from the bus when ready
            end
        end
    endfunction

    always_comb begin
        lookup(source_1_index, source_1_ready, source_1_value, source_1_tag);
        lookup(source_2_index, source_2_ready, source_2_value, source_2_tag);
    end

    always_comb begin
        for (int r = 1; r < 32; r++) begin
            retire[r] = busy[r] && result_valid && (result_tag == tags[r]);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            for (int r = 1; r < 32; r++) begin
                if (issue_accept && destination_index == `REG_INDEX_WIDTH'(r)) begin
                    busy[r] <= 1'b1; // Newer producer wins over retire
                end else if (retire[r]) begin
                    busy[r] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int r = 1; r < 32; r++) begin
            if (retire[r]) begin
                values[r] <= result_value;
            end
            if (issue_accept && destination_index == `REG_INDEX_WIDTH'(r)) begin
                tags[r] <= issue_tag;
            end
        end
    end

endmodule

/* station_pool.sv */
`include "cpu_macros.svh"

module station_pool (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        instruction_valid,
    input  logic                        decode_known,
    input  cpu_pkg::alu_op_e            alu_op,
    input  logic                        use_immediate,
    input  logic [`XLEN-1:0]            immediate,
    input  logic [`REG_INDEX_WIDTH-1:0] destination_index,
    input  logic                        source_1_ready,
    input  logic [`XLEN-1:0]            source_1_value,
    input  logic [`TAG_WIDTH-1:0]       source_1_tag,
    input  logic                        source_2_ready,
    input  logic [`XLEN-1:0]            source_2_value,
    input  logic [`TAG_WIDTH-1:0]       source_2_tag,
    output logic                        issue_accept,
    output logic [`TAG_WIDTH-1:0]       issue_tag,
    output logic                        result_valid,
    output logic [`TAG_WIDTH-1:0]       result_tag,
    output logic [`XLEN-1:0]            result_value,
    output logic [`REG_INDEX_WIDTH-1:0] result_destination
);
    import cpu_pkg::*;

    alu_op_e                     operation   [`STATION_COUNT];
    logic [`XLEN-1:0]            operand_1   [`STATION_COUNT];
    logic [`XLEN-1:0]            operand_2   [`STATION_COUNT];
    logic [`TAG_WIDTH-1:0]       wait_tag_1  [`STATION_COUNT];
    logic [`TAG_WIDTH-1:0]       wait_tag_2  [`STATION_COUNT];
    logic [`REG_INDEX_WIDTH-1:0] destination [`STATION_COUNT];
    logic [`STATION_COUNT-1:0]   occupied;
    logic [`STATION_COUNT-1:0]   loaded_1;
    logic [`STATION_COUNT-1:0]   loaded_2;
    logic [`STATION_COUNT-1:0]   wake_1;
    logic [`STATION_COUNT-1:0]   wake_2;
    logic                        free_found;
    logic                        winner_found;
    logic [`TAG_WIDTH-1:0]       winner;
    logic                        issue_ready_2;
    logic [`XLEN-1:0]            issue_value_2;
    logic [`XLEN-1:0]            alu_a;
    logic [`XLEN-1:0]            alu_b;
    logic [`XLEN-1:0]            alu_result;

    always_comb begin
        free_found   = 1'b0;
        issue_tag    = '0;
        winner_found = 1'b0;
        winner       = '0;
        for (int s = `STATION_COUNT - 1; s >= 0; s--) begin // Lowest index ends up chosen
            if (!occupied[s]) begin
                free_found = 1'b1;
                issue_tag  = `TAG_WIDTH'(s);
            end
            if (occupied[s] && loaded_1[s] && loaded_2[s]) begin
                winner_found = 1'b1;
                winner       = `TAG_WIDTH'(s);
            end
            wake_1[s] = occupied[s] && !loaded_1[s] && result_valid && wait_tag_1[s] == result_tag;
            wake_2[s] = occupied[s] && !loaded_2[s] && result_valid && wait_tag_2[s] == result_tag;
        end
    end

    assign issue_accept  = instruction_valid && decode_known && free_found;
    assign issue_ready_2 = use_immediate || source_2_ready;
    assign issue_value_2 = use_immediate ? immediate : source_2_value;

    assign alu_a = operand_1[winner];
    assign alu_b = operand_2[winner];

    always_comb begin
        case (operation[winner])
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_SLTU: alu_result = `XLEN'(alu_a < alu_b);
            ALU_SLT:  alu_result = `XLEN'($signed(alu_a) < $signed(alu_b));
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            occupied     <= '0;
            loaded_1     <= '0;
            loaded_2     <= '0;
            result_valid <= 1'b0;
        end else begin
            loaded_1 <= loaded_1 | wake_1;
            loaded_2 <= loaded_2 | wake_2;
            if (issue_accept) begin
                occupied[issue_tag] <= 1'b1;
                loaded_1[issue_tag] <= source_1_ready;
                loaded_2[issue_tag] <= issue_ready_2;
            end
            if (result_valid) begin
                occupied[result_tag] <= 1'b0; // Free as the pulse ends
                result_valid         <= 1'b0;
            end else if (winner_found) begin
                result_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < `STATION_COUNT; s++) begin
            if (wake_1[s]) begin
                operand_1[s] <= result_value;
            end
            if (wake_2[s]) begin
                operand_2[s] <= result_value;
            end
        end
        if (issue_accept) begin
            operation[issue_tag]   <= alu_op;
            operand_1[issue_tag]   <= source_1_value;
            operand_2[issue_tag]   <= issue_value_2;
            wait_tag_1[issue_tag]  <= source_1_tag;
            wait_tag_2[issue_tag]  <= source_2_tag;
            destination[issue_tag] <= destination_index;
        end
        if (!result_valid && winner_found) begin
            result_tag         <= winner;
            result_value       <= alu_result;
            result_destination <= destination[winner];
        end
    end

endmodule

/* tb_cpu.sv */
`include "cpu_macros.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int ROWS        = 64;
    localparam int IMM         = 16;     // Added to the ALU op for the immediate form
    localparam int RAW         = 31;     // Word taken as is from the immediate column
    localparam int CYCLE_LIMIT = 20000;

    logic                        clock = 1'b0;
    logic                        reset = 1'b1;
    logic [`XLEN-1:0]            memory_address;
    logic [`XLEN-1:0]            memory_data_in = '0;
    logic [`XLEN-1:0]            memory_data_out;
    logic [1:0]                  memory_data_size;
    logic                        memory_enable;
    logic                        memory_operation;
    logic                        memory_ready = 1'b0;
    logic                        result_valid;
    logic [`TAG_WIDTH-1:0]       result_tag;
    logic [`XLEN-1:0]            result_value;
    logic [`REG_INDEX_WIDTH-1:0] result_destination;

    int          row_op    [ROWS];
    int          row_rd    [ROWS];
    int          row_rs1   [ROWS];
    int          row_rs2   [ROWS];
    int          row_imm   [ROWS];
    int          row_delay [ROWS];   // Memory delay for the row, -1 for random
    int          row_count = 0;
    logic [31:0] program_memory [ROWS];
    logic [31:0] lfsr = 32'h456189af;
    logic        pending = 1'b0;
    logic [1:0]  wait_count = '0;
    int          error_count;
    int          outstanding;
    logic        model_ready;
    int          cycles;

    cpu_top uut (.*);

    cpu_checker #(.ROWS(ROWS)) result_check (
        .clock, .reset, .memory_data_out, .memory_data_size, .memory_operation,
        .result_valid, .result_value, .result_destination,
        .row_op, .row_rd, .row_rs1, .row_rs2, .row_imm, .row_count,
        .error_count, .outstanding, .model_ready
    );

    always #2 clock = ~clock;

    task automatic add_row(input int op, rd, rs1, rs2, imm, delay);
        row_op[row_count]    = op;
        row_rd[row_count]    = rd;
        row_rs1[row_count]   = rs1;
        row_rs2[row_count]   = rs2;
        row_imm[row_count]   = imm;
        row_delay[row_count] = delay;
        row_count++;
    endtask

    function automatic logic [31:0] encode(input int op, rd, rs1, rs2, imm);
        logic [3:0] alu;
        logic [2:0] f3;
        logic [6:0] f7;
        alu = 4'(op % IMM);
        case (alu)
            ALU_SLL:          f3 = 3'b001;
            ALU_SLT:          f3 = 3'b010;
            ALU_SLTU:         f3 = 3'b011;
            ALU_XOR:          f3 = 3'b100;
            ALU_SRL, ALU_SRA: f3 = 3'b101;
            ALU_OR:           f3 = 3'b110;
            ALU_AND:          f3 = 3'b111;
            default:          f3 = 3'b000;
        endcase
        f7 = (alu == ALU_SUB || alu == ALU_SRA) ? 7'b0100000 : 7'b0000000;
        if (op == RAW) return imm;
        if (op >= IMM && (alu == ALU_SLL || alu == ALU_SRL || alu == ALU_SRA))
            return {f7, 5'(imm), 5'(rs1), f3, 5'(rd), OPCODE_OP_IMM};
        if (op >= IMM) return {12'(imm), 5'(rs1), f3, 5'(rd), OPCODE_OP_IMM};
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPCODE_OP};
    endfunction

    // One LFSR step per bit taken
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [1:0] pick_delay(input logic [`XLEN-1:0] address);
        int row;
        row = int'(address >> 2);
        if (row < row_count && row_delay[row] >= 0) return 2'(row_delay[row]);
        return {take_bit(), take_bit()};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [`XLEN-1:0] address);
        int row;
        row = int'(address >> 2);
        if (row < row_count) return program_memory[row];
        return 32'h0000_0013; // ADDI x0, x0, 0
    endfunction

    always @(posedge clock) begin
        logic [1:0] delay;
        if (reset || !memory_enable) begin
            memory_ready <= 1'b0;
            pending      <= 1'b0;
        end else if (!memory_ready) begin
            if (!pending) begin
                delay = pick_delay(memory_address);
                if (delay == 2'd0) begin
                    memory_ready   <= 1'b1;
                    memory_data_in <= fetch_word(memory_address);
                end else begin
                    pending    <= 1'b1;
                    wait_count <= delay - 2'd1;
                end
            end else if (wait_count == 2'd0) begin
                memory_ready   <= 1'b1;
                memory_data_in <= fetch_word(memory_address);
                pending        <= 1'b0;
            end else begin
                wait_count <= wait_count - 2'd1;
            end
        end
    end

    initial begin
        add_row(IMM + ALU_ADD, 1, 0, 0, -7, -1);    // Seed registers
        add_row(IMM + ALU_ADD, 2, 0, 0, 100, -1);
        add_row(IMM + ALU_ADD, 3, 0, 0, 2047, -1);
        add_row(IMM + ALU_ADD, 4, 0, 0, -2048, -1);
        add_row(IMM + ALU_ADD, 5, 0, 0, 13, -1);
        add_row(IMM + ALU_SLT, 6, 1, 0, -3, -1);
        add_row(IMM + ALU_SLTU, 7, 1, 0, 5, -1);
        add_row(IMM + ALU_XOR, 8, 2, 0, 'h55, -1);
        add_row(IMM + ALU_OR, 9, 3, 0, -256, -1);
        add_row(IMM + ALU_AND, 10, 4, 0, 'h7f0, -1);
        add_row(IMM + ALU_SLL, 11, 5, 0, 28, -1);
        add_row(IMM + ALU_SRL, 12, 1, 0, 4, -1);
        add_row(IMM + ALU_SRA, 13, 1, 0, 2, -1);
        add_row(ALU_ADD, 14, 1, 2, 0, -1);
        add_row(ALU_SUB, 15, 1, 2, 0, -1);
        add_row(ALU_SLL, 16, 2, 5, 0, -1);
        add_row(ALU_SLT, 17, 1, 2, 0, -1);
        add_row(ALU_SLTU, 18, 1, 2, 0, -1);
        add_row(ALU_XOR, 19, 3, 4, 0, -1);
        add_row(ALU_OR, 20, 1, 5, 0, -1);
        add_row(ALU_AND, 21, 2, 3, 0, -1);
        add_row(ALU_SRL, 22, 1, 5, 0, -1);
        add_row(ALU_SRA, 23, 4, 5, 0, -1);
        add_row(ALU_SUB, 24, 4, 1, 0, -1);
        add_row(IMM + ALU_ADD, 25, 2, 0, 1, 0);     // Chain with no fetch delay
        add_row(ALU_ADD, 25, 25, 1, 0, 0);
        add_row(ALU_SUB, 26, 2, 25, 0, 0);
        add_row(ALU_SLL, 26, 26, 5, 0, 0);
        add_row(IMM + ALU_XOR, 27, 26, 0, -1, 3);   // Chain with long delay
        add_row(ALU_ADD, 27, 1, 27, 0, 3);
        add_row(ALU_ADD, 28, 27, 1, 0, 0);          // Five readers of x27
        add_row(ALU_SUB, 29, 27, 2, 0, 0);
        add_row(ALU_OR, 30, 27, 3, 0, 0);
        add_row(ALU_AND, 31, 27, 4, 0, 0);
        add_row(ALU_XOR, 6, 27, 5, 0, 0);
        add_row(IMM + ALU_ADD, 0, 1, 0, 5, -1);
        add_row(ALU_ADD, 0, 2, 3, 0, -1);
        add_row(RAW, 0, 0, 0, 32'hfe00_8133, -1);   // Bad funct7 aimed at x2
        add_row(RAW, 0, 0, 0, 32'h0000_0f83, -1);   // Load into x31
        add_row(ALU_ADD, 7, 0, 0, 0, -1);
        add_row(IMM + ALU_ADD, 8, 0, 0, 0, -1);
        add_row(ALU_ADD, 9, 2, 0, 0, -1);
        add_row(ALU_OR, 10, 31, 28, 0, -1);
        for (int i = 0; i < row_count; i++) begin
            program_memory[i] = encode(row_op[i], row_rd[i], row_rs1[i], row_rs2[i], row_imm[i]);
        end

        repeat (5) @(posedge clock);
        reset <= 1'b0;

        cycles = 0;
        while (!(model_ready && outstanding == 0) && cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: %0d results never appeared on the trace port", outstanding);
        end
        repeat (40) @(posedge clock); // Catch stray pulses
        $display("errors %0d, unmatched results %0d", error_count, outstanding);
        if (model_ready && outstanding == 0 && error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
